// ==== Makefile ====
TOP = tb_layer_norm

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f layer_norm.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Wall -f layer_norm.f --top-module layer_norm

clean:
	rm -rf obj_dir

// ==== layer_norm.f ====
+incdir+.
lnorm_pkg.sv
lnorm_center.sv
lnorm_variance.sv
lnorm_sqrt.sv
lnorm_scale.sv
layer_norm.sv
tb_layer_norm.sv

// ==== layer_norm.sv ====
`timescale 1ns/1ns

module layer_norm (
    input  logic               clk,
    input  logic               rst,
    input  lnorm_pkg::sample_t in_data,
    input  logic               in_valid,
    output logic               in_ready,
    output lnorm_pkg::sample_t out_data,
    output logic               out_valid,
    input  logic               out_ready
);
    import lnorm_pkg::*;

    // one shared enable, every stage moves together or holds
    logic       advance;
    ctr_beat_t  ctr_beat;
    var_beat_t  var_beat;
    root_beat_t root_beat;

    // input is taken whenever the pipe moves
    assign in_ready = advance;

    // stage 1, centre on the mean
    lnorm_center u_center (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .in_data  (in_data),
        .in_valid (in_valid),
        .ctr_out  (ctr_beat)
    );

    // stage 2, variance
    lnorm_variance u_variance (
        .clk     (clk),
        .rst     (rst),
        .advance (advance),
        .ctr_in  (ctr_beat),
        .var_out (var_beat)
    );

    // stages 3 to 6, standard deviation
    lnorm_sqrt u_sqrt (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .var_in   (var_beat),
        .root_out (root_beat)
    );

    // stage 7, divide and saturate, also owns the flow control
    lnorm_scale u_scale (
        .clk       (clk),
        .rst       (rst),
        .root_in   (root_beat),
        .out_ready (out_ready),
        .advance   (advance),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

// ==== lnorm_center.sv ====
`timescale 1ns/1ns
`include "lnorm_defs.svh"

module lnorm_center (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  lnorm_pkg::sample_t   in_data,
    input  logic                 in_valid,
    output lnorm_pkg::ctr_beat_t ctr_out
);
    import lnorm_pkg::*;

    // sum of eight q4.4 values needs three more integer bits
    localparam int SUM_W = `LN_IN_W + `LN_DEPTH_LOG2;

    logic signed [SUM_W-1:0]     sum;
    logic signed [`LN_CTR_W-1:0] x_scaled;
    ctr_beat_t                   ctr_next;

    // sample sum s, units of 2^-4
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            sum = sum + $signed(in_data[i]);
        end
    end

    // c_i = DEPTH*x_i - s
    // the mean is s/DEPTH, so scaling x instead of dividing s
    // keeps the centring exact with log2(DEPTH) extra fraction bits
    always_comb
    begin
        ctr_next.valid = in_valid;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            x_scaled = $signed(in_data[i]);
            x_scaled = x_scaled <<< `LN_DEPTH_LOG2;
            ctr_next.ctr[i] = x_scaled - sum;
        end
    end

    // a low in_valid turns into a bubble in the pipe
    always_ff @(posedge clk)
    begin
        if (advance)
            ctr_out <= ctr_next;
        if (rst)
            ctr_out.valid <= 1'b0;
    end

endmodule

// ==== lnorm_defs.svh ====
`ifndef LNORM_DEFS_SVH
`define LNORM_DEFS_SVH

// elements per sample, must be a power of two
`define LN_DEPTH        8
`define LN_DEPTH_LOG2   3

// q4.4 element format on input and output
`define LN_IN_W         8
`define LN_IN_FRAC      4

// centred element c_i = 8*x_i - s, units of 2^-7
`define LN_CTR_W        13
// variance q, units of 2^-8
`define LN_VAR_W        16

// square root of q*256, radicand and root widths
`define LN_RAD_W        24
`define LN_ROOT_W       12
// partial remainder never exceeds twice the partial root
`define LN_REM_W        14
`define LN_SQRT_STAGES  4
`define LN_SQRT_BITS    3

`endif

// ==== lnorm_pkg.sv ====
`include "lnorm_defs.svh"

package lnorm_pkg;

    // signed q4.4 element
    typedef logic signed [`LN_IN_W-1:0] elem_t;

    // one sample, element 0 in the low bits
    typedef elem_t [`LN_DEPTH-1:0] sample_t;

    // centred element, three more fraction bits than the input
    typedef logic signed [`LN_CTR_W-1:0] ctr_t;
    typedef ctr_t [`LN_DEPTH-1:0] ctr_vec_t;

    // stage 1 -> 2
    typedef struct packed {
        logic     valid;
        ctr_vec_t ctr;
    } ctr_beat_t;

    // stage 2 -> 3
    typedef struct packed {
        logic                 valid;
        logic [`LN_VAR_W-1:0] q;
        ctr_vec_t             ctr;
    } var_beat_t;

    // between sqrt stages and on to stage 7
    // root holds r once the last sqrt stage is done
    typedef struct packed {
        logic                  valid;
        logic [`LN_REM_W-1:0]  rem;
        logic [`LN_ROOT_W-1:0] root;
        logic [`LN_RAD_W-1:0]  rad;
        ctr_vec_t              ctr;
    } root_beat_t;

endpackage

// ==== lnorm_scale.sv ====
`timescale 1ns/1ns
`include "lnorm_defs.svh"

module lnorm_scale (
    input  logic                  clk,
    input  logic                  rst,
    input  lnorm_pkg::root_beat_t root_in,
    input  logic                  out_ready,
    output logic                  advance,
    output lnorm_pkg::sample_t    out_data,
    output logic                  out_valid
);
    import lnorm_pkg::*;

    // c is 2^-7, r is 2^-8, y is 2^-4
    // y = c * 2^(4 + 8 - 7) / r
    localparam int CTR_FRAC = `LN_IN_FRAC + `LN_DEPTH_LOG2;
    localparam int NUM_SHIFT = `LN_IN_FRAC + 2 * `LN_IN_FRAC - CTR_FRAC;
    localparam int NUM_W = `LN_CTR_W + NUM_SHIFT;
    // root is unsigned, one more bit keeps it positive as a signed divisor
    localparam int DEN_W = `LN_ROOT_W + 1;
    localparam int Y_MAX = 2 ** (`LN_IN_W - 1) - 1;
    localparam int Y_MIN = -(2 ** (`LN_IN_W - 1));

    logic signed [NUM_W-1:0] num;
    logic signed [NUM_W-1:0] quo;
    logic signed [DEN_W-1:0] den;
    logic                    root_zero;
    sample_t                 y;

    // the whole pipe moves when the output slot is free or being taken
    assign advance = !out_valid || out_ready;

    assign root_zero = (root_in.root == '0);

    always_comb
    begin
        // dummy divisor of 1 when r is 0, that result is discarded
        if (root_zero)
            den = DEN_W'(1);
        else
            den = $signed({1'b0, root_in.root});

        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            num = $signed(root_in.ctr[i]);
            num = num <<< NUM_SHIFT;
            // signed divide truncates toward zero
            quo = num / den;
            if (root_zero)
                y[i] = '0;
            else if (quo > Y_MAX)
                y[i] = elem_t'(Y_MAX);
            else if (quo < Y_MIN)
                y[i] = elem_t'(Y_MIN);
            else
                y[i] = quo[`LN_IN_W-1:0];
        end
    end

    // output register, held while out_ready is low
    always_ff @(posedge clk)
    begin
        if (rst)
            out_valid <= 1'b0;
        else if (advance)
            out_valid <= root_in.valid;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            out_data <= y;
    end

endmodule

// ==== lnorm_sqrt.sv ====
`timescale 1ns/1ns
`include "lnorm_defs.svh"

module lnorm_sqrt (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  lnorm_pkg::var_beat_t  var_in,
    output lnorm_pkg::root_beat_t root_out
);
    import lnorm_pkg::*;

    // q*256 so the root comes out in units of 2^-8
    localparam int RAD_SHIFT = 2 * `LN_IN_FRAC;
    // remainder with the next radicand digit pair appended
    localparam int ACC_W = `LN_REM_W + 2;

    // link[0] is the loaded radicand, link[g+1] the register of stage g
    root_beat_t link [0:`LN_SQRT_STAGES];

    // fresh sample, remainder and root start at zero
    always_comb
    begin
        link[0].valid = var_in.valid;
        link[0].rem   = '0;
        link[0].root  = '0;
        link[0].rad   = {var_in.q, {RAD_SHIFT{1'b0}}};
        link[0].ctr   = var_in.ctr;
    end

    for (genvar g = 0; g < `LN_SQRT_STAGES; g++)
    begin : g_stage
        root_beat_t       step;
        root_beat_t       beat_q;
        logic [ACC_W-1:0] acc;
        logic [ACC_W-1:0] trial;
        logic [ACC_W-1:0] diff;

        // restoring digit-by-digit root, LN_SQRT_BITS root bits per stage
        always_comb
        begin
            step  = link[g];
            acc   = '0;
            trial = '0;
            diff  = '0;
            for (int b = 0; b < `LN_SQRT_BITS; b++)
            begin
                // bring down the next two radicand bits
                acc      = {step.rem, step.rad[`LN_RAD_W-1 -: 2]};
                step.rad = step.rad << 2;
                // trial divisor 4*root + 1
                trial    = {2'b00, step.root, 2'b01};
                diff     = acc - trial;
                if (acc >= trial)
                begin
                    step.rem  = diff[`LN_REM_W-1:0];
                    step.root = {step.root[`LN_ROOT_W-2:0], 1'b1};
                end
                else
                begin
                    // restore, the remainder keeps the appended bits
                    step.rem  = acc[`LN_REM_W-1:0];
                    step.root = {step.root[`LN_ROOT_W-2:0], 1'b0};
                end
            end
        end

        // each stage holds its own sample while the pipe is stalled
        always_ff @(posedge clk)
        begin
            if (advance)
                beat_q <= step;
            if (rst)
                beat_q.valid <= 1'b0;
        end

        assign link[g + 1] = beat_q;
    end

    // after the last stage root is r = floor(sqrt(q*256))
    assign root_out = link[`LN_SQRT_STAGES];

endmodule

// ==== lnorm_variance.sv ====
`timescale 1ns/1ns
`include "lnorm_defs.svh"

module lnorm_variance (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  lnorm_pkg::ctr_beat_t ctr_in,
    output lnorm_pkg::var_beat_t var_out
);
    import lnorm_pkg::*;

    // sum of c_i^2 is in units of 2^-14, q wants 2^-8 and a divide by DEPTH,
    // so the total shift is 3*log2(DEPTH)
    localparam int VAR_SHIFT = 3 * `LN_DEPTH_LOG2;
    // bounded sum of squares fits here, a full 26 bit product is not needed
    localparam int SUMSQ_W = `LN_VAR_W + VAR_SHIFT;

    logic signed [`LN_CTR_W-1:0] ci;
    // heap-ordered adder tree, node 1 is the root, leaves at DEPTH..2*DEPTH-1
    logic [SUMSQ_W-1:0]          node [1:2*`LN_DEPTH-1];
    var_beat_t                   var_next;

    always_comb
    begin
        // leaves hold the squares
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            ci = ctr_in.ctr[i];
            node[`LN_DEPTH + i] = ci * ci;
        end
        // walk upward, each node adds its two children
        for (int k = `LN_DEPTH - 1; k > 0; k--)
        begin
            node[k] = node[2 * k] + node[2 * k + 1];
        end
    end

    always_comb
    begin
        var_next.valid = ctr_in.valid;
        // floor by truncation
        var_next.q = node[1][SUMSQ_W-1:VAR_SHIFT];
        // centred vector rides along for the final divide
        var_next.ctr = ctr_in.ctr;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            var_out <= var_next;
        if (rst)
            var_out.valid <= 1'b0;
    end

endmodule

// ==== tb_layer_norm.sv ====
`timescale 1ns/1ns
`include "lnorm_defs.svh"

module tb_layer_norm;
    import lnorm_pkg::*;

    localparam int N_DIRECTED = 5;
    localparam int N_BURST = 40;
    localparam int N_STALL = 60;
    localparam int TOTAL_SAMPLES = N_DIRECTED + N_BURST + N_STALL;
    localparam longint WATCHDOG_NS = (TOTAL_SAMPLES + 20) * 4 * 100;
    // center, variance, sqrt stages, scale
    localparam int LATENCY = 1 + 1 + `LN_SQRT_STAGES + 1;

    logic    clk;
    logic    rst;
    sample_t in_data;
    logic    in_valid;
    logic    in_ready;
    sample_t out_data;
    logic    out_valid;
    logic    out_ready;

    // reference queue, head copied into plain variables for the assertions
    sample_t exp_q [$];
    int      stamp_q [$];
    sample_t exp_head;
    int      head_stamp;
    int      exp_count;

    // transfers seen at the rising edge, booked at the falling edge
    logic    in_xfer_c;
    sample_t in_data_c;
    int      in_stamp_c;
    logic    out_xfer_c;
    int      adv_edges;
    logic    any_accepted;

    int          in_count;
    int          out_count;
    int          data_errors;
    int          timing_errors;
    int          protocol_errors;
    logic        stall_mode;
    logic [31:0] rng_state;
    logic [31:0] bp_state;

    layer_norm DUT (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] t;
        t = v;
        t = t ^ (t << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // largest r with r*r <= n, bit by bit from the top
    function automatic int int_sqrt(input int n);
        int r;
        r = 0;
        for (int b = 2048; b > 0; b = b / 2)
        begin
            if ((r + b) * (r + b) <= n)
                r = r + b;
        end
        return r;
    endfunction

    // expected output from the arithmetic rules of the unit
    function automatic sample_t normalize_ref(input sample_t x);
        int      s;
        int      c [`LN_DEPTH];
        int      sumsq;
        int      q;
        int      r;
        int      y;
        sample_t res;
        s = 0;
        for (int i = 0; i < `LN_DEPTH; i++)
            s = s + int'($signed(x[i]));
        sumsq = 0;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            // centred value in units of 2^-7
            c[i] = 8 * int'($signed(x[i])) - s;
            sumsq = sumsq + c[i] * c[i];
        end
        // variance in 2^-8, then its root in 2^-8
        q = sumsq / 512;
        r = int_sqrt(q * 256);
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            if (r == 0)
                y = 0;
            else
                y = (32 * c[i]) / r;
            if (y > 127)
                y = 127;
            if (y < -128)
                y = -128;
            res[i] = elem_t'(y);
        end
        return res;
    endfunction

    // flat, outliers on both sides, a ramp and a tiny spread
    // the tiny spread has nonzero c_i but still floors to r = 0
    function automatic sample_t directed_sample(input int kind);
        sample_t v;
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            case (kind)
                0: v[i] = 8'sh25;
                1: v[i] = (i == 3) ? 8'sd127 : 8'sd0;
                2: v[i] = (i == 5) ? -8'sd128 : 8'sd16;
                3: v[i] = elem_t'(i * 20 - 70);
                default: v[i] = (i == 0) ? 8'sd1 : 8'sd0;
            endcase
        end
        return v;
    endfunction

    function sample_t random_sample();
        logic [31:0] mode;
        logic [31:0] base;
        logic [31:0] w;
        sample_t     v;
        mode = next_rand();
        base = next_rand();
        for (int i = 0; i < `LN_DEPTH; i++)
        begin
            w = next_rand();
            // a tight cluster now and then keeps r small
            if (mode[1:0] == 2'b00)
                v[i] = base[7:0] + {6'b0, w[1:0]};
            else
                v[i] = w[7:0];
        end
        return v;
    endfunction

    // hold the beat until a rising edge sees in_ready high
    task send_sample(input sample_t s);
        in_data  = s;
        in_valid = 1'b1;
        do
            @(posedge clk);
        while (!in_ready);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    always @(posedge clk)
    begin
        in_xfer_c  <= !rst && in_valid && in_ready;
        in_data_c  <= in_data;
        in_stamp_c <= adv_edges;
        out_xfer_c <= !rst && out_valid && out_ready;
        // counts edges on which the whole pipe moved
        if (!rst && in_ready)
            adv_edges <= adv_edges + 1;
    end

    // reference bookkeeping away from the rising edge
    always @(negedge clk)
    begin
        if (in_xfer_c)
        begin
            exp_q.push_back(normalize_ref(in_data_c));
            stamp_q.push_back(in_stamp_c);
            in_count++;
            any_accepted = 1'b1;
        end
        if (out_xfer_c)
        begin
            if (exp_q.size() > 0)
            begin
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
            out_count++;
        end
        exp_count  = exp_q.size();
        exp_head   = (exp_count > 0) ? exp_q[0] : '0;
        head_stamp = (exp_count > 0) ? stamp_q[0] : 0;
    end

    // random back-pressure, own generator so stimulus order stays fixed
    always @(negedge clk)
    begin
        if (stall_mode)
        begin
            bp_state  = xorshift32(bp_state);
            out_ready = (bp_state[2:0] > 3'd2);
        end
        else
            out_ready = 1'b1;
    end

    idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !any_accepted |-> (!out_valid && in_ready))
    else
    begin
        protocol_errors++;
        $display("%0t: output busy or input not ready before the first sample", $time);
    end

    data_match: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (out_data == exp_head))
    else
    begin
        data_errors++;
        $display("[FAIL] %0t out_data: got %h expected %h",
                 $time, $sampled(out_data), $sampled(exp_head));
    end

    // holds at every edge the beat sits in the output register
    latency_match: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> ((adv_edges - head_stamp) == LATENCY))
    else
    begin
        timing_errors++;
        $display("[FAIL] %0t out_valid latency: got %0d expected %0d",
                 $time, $sampled(adv_edges) - $sampled(head_stamp), LATENCY);
    end

    no_extra_beat: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (exp_count > 0))
    else
    begin
        protocol_errors++;
        $display("%0t: output beat with no sample outstanding", $time);
    end

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else
    begin
        protocol_errors++;
        $display("%0t: output beat changed or dropped while stalled", $time);
    end

    ready_low_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |-> !in_ready)
    else
    begin
        protocol_errors++;
        $display("%0t: in_ready high while the output is stalled", $time);
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, %0d of %0d samples out",
                 WATCHDOG_NS, out_count, TOTAL_SAMPLES);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        logic [31:0] w;
        int          total;
        clk             = 1'b0;
        rst             = 1'b1;
        in_data         = '0;
        in_valid        = 1'b0;
        out_ready       = 1'b1;
        stall_mode      = 1'b0;
        rng_state       = 32'h6b4bd9b4;
        bp_state        = xorshift32(32'h6b4bd9b4);
        in_xfer_c       = 1'b0;
        in_data_c       = '0;
        in_stamp_c      = 0;
        out_xfer_c      = 1'b0;
        adv_edges       = 0;
        any_accepted    = 1'b0;
        exp_count       = 0;
        exp_head        = '0;
        head_stamp      = 0;
        in_count        = 0;
        out_count       = 0;
        data_errors     = 0;
        timing_errors   = 0;
        protocol_errors = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // idle a few cycles so the post-reset state is seen
        repeat (4) @(negedge clk);

        for (int k = 0; k < N_DIRECTED; k++)
            send_sample(directed_sample(k));
        // back to back with the output always ready
        for (int k = 0; k < N_BURST; k++)
            send_sample(random_sample());
        // last transfer is booked by the time of the next rising edge
        @(posedge clk);
        wait (exp_count == 0);
        repeat (2) @(negedge clk);

        // random stalls at the output, random gaps at the input
        stall_mode = 1'b1;
        for (int k = 0; k < N_STALL; k++)
        begin
            w = next_rand();
            if (w[1:0] == 2'b00)
                repeat (w[3:2]) @(negedge clk);
            send_sample(random_sample());
        end
        @(posedge clk);
        wait (exp_count == 0);
        stall_mode = 1'b0;
        repeat (4) @(negedge clk);

        if (in_count != TOTAL_SAMPLES || out_count != in_count || exp_q.size() != 0)
        begin
            protocol_errors++;
            $display("sample count mismatch, %0d sent, %0d accepted, %0d received, %0d left",
                     TOTAL_SAMPLES, in_count, out_count, exp_q.size());
        end

        total = data_errors + timing_errors + protocol_errors;
        $display("errors: data %0d, timing %0d, protocol %0d; samples in %0d, out %0d",
                 data_errors, timing_errors, protocol_errors, in_count, out_count);
        if (total == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
